/* all.f */
verilog/amber_sys_pkg.sv
verilog/wb_decoder.sv
verilog/boot_mem.sv
verilog/test_module.sv
verilog/timer_module.sv
verilog/interrupt_controller.sv
verilog/amber_sys.sv
verification/amber_sys_asserts.sv
verification/tb_amber_sys.sv

/* run_sim.sh */
#!/bin/sh
# Build the fabric testbench with Verilator, run it and scan the log for the verdict

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_amber_sys -f all.f -o tb_amber_sys
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_amber_sys > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "Simulation run ended with status $status"
    exit 1
fi
if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
    echo "No verdict found in $LOG"
    exit 1
fi
exit 0

/* verification/tb_amber_sys.sv */
// Self-checking testbench for the fabric; random bus traffic against a reference model
`timescale 1ns/1ns

module tb_amber_sys;

    import amber_sys_pkg::*;

    localparam int TIMERS      = 3;
    localparam int NSRC        = TIMERS + 2;
    localparam int BOOT_WORDS  = 256;
    localparam int BUS_TIMEOUT = 20;

    logic        clk;
    logic        reset;
    wb_adr_t     wb_adr;
    logic [3:0]  wb_sel;
    logic        wb_we;
    logic [31:0] wb_dat_w;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        wb_err;
    logic [3:0]  led;
    logic        irq;
    logic        firq;

    // Reference model state
    logic [31:0]     boot_model [BOOT_WORDS];
    logic [3:0]      led_m;
    logic [1:0]      test_m;
    logic [NSRC-1:0] irq_en_m;
    logic [NSRC-1:0] firq_en_m;
    logic [TIMERS-1:0] flag_m;

    int checks;
    int errors;
    int timeouts;

    amber_sys u_dut (
        .i_clk    ( clk      ),
        .i_reset  ( reset    ),
        .i_wb_adr ( wb_adr   ),
        .i_wb_sel ( wb_sel   ),
        .i_wb_we  ( wb_we    ),
        .i_wb_dat ( wb_dat_w ),
        .i_wb_cyc ( wb_cyc   ),
        .i_wb_stb ( wb_stb   ),
        .o_wb_dat ( wb_dat_r ),
        .o_wb_ack ( wb_ack   ),
        .o_wb_err ( wb_err   ),
        .o_led    ( led      ),
        .o_irq    ( irq      ),
        .o_firq   ( firq     )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, msg, actual, expected);
        end
    endtask

    function automatic logic [31:0] make_adr(input logic [3:0] slave, input logic [15:0] offset);
        wb_adr_t a;
        a.raw      = '0;
        a.f.slave  = slave;
        a.f.offset = offset;
        return a.raw;
    endfunction

    // Byte-merge per select bit
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] sel);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [NSRC-1:0] raw_model();
        logic [NSRC-1:0] r;
        r = '0;
        r[SRC_TEST_IRQ]  = test_m[0];
        r[SRC_TEST_FIRQ] = test_m[1];
        r[SRC_TIMER_BASE +: TIMERS] = flag_m;
        return r;
    endfunction

    // One classic cycle; starts and ends on a falling edge, idle cycle after
    task automatic bus_access(input logic [31:0] adr, input logic we, input logic [3:0] sel,
                              input logic [31:0] wdat, output logic [31:0] rdat,
                              output logic got_ack, output logic got_err);
        int cycles;
        cycles   = 0;
        got_ack  = 1'b0;
        got_err  = 1'b0;
        wb_adr   = adr;
        wb_we    = we;
        wb_sel   = sel;
        wb_dat_w = wdat;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        while (!got_ack && !got_err && cycles < BUS_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            got_ack = wb_ack;
            got_err = wb_err;
        end
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!got_ack && !got_err) begin
            timeouts++;
            $display("Bus timeout at %0t: no ack or err for address %h", $time, adr);
        end else begin
            check(cycles, 1, "response latency");
        end
        @(negedge clk);
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel = 4'hf);
        logic [31:0] rdat;
        logic ack;
        logic err;
        bus_access(adr, 1'b1, sel, dat, rdat, ack, err);
        check({ack, err}, 2'b10, "write response");
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] rdat);
        logic ack;
        logic err;
        bus_access(adr, 1'b0, 4'hf, 32'h0, rdat, ack, err);
        check({ack, err}, 2'b10, "read response");
    endtask

    // Pins two cycles on, then raw and masked status through the bus
    task automatic verify_ic(input string tag);
        logic [31:0]     rdat;
        logic [NSRC-1:0] raw;
        raw = raw_model();
        repeat (2) @(negedge clk);
        check(irq, |(raw & irq_en_m), {tag, " o_irq"});
        check(firq, |(raw & firq_en_m), {tag, " o_firq"});
        wb_read(make_adr(SLV_IC, IC_RAW), rdat);
        check(rdat, 32'(raw), {tag, " raw"});
        wb_read(make_adr(SLV_IC, IC_IRQ_STATUS), rdat);
        check(rdat, 32'(raw & irq_en_m), {tag, " irq status"});
        wb_read(make_adr(SLV_IC, IC_FIRQ_STATUS), rdat);
        check(rdat, 32'(raw & firq_en_m), {tag, " firq status"});
    endtask

    // ------------------------------
    // Test sequences
    // ------------------------------
    task automatic test_boot_mem();
        logic [31:0] rdat;
        logic [31:0] dat;
        logic [3:0]  sel;
        int          idx;
        // Fill pattern over every word index
        for (int i = 0; i < BOOT_WORDS; i++) begin
            boot_model[i] = 32'h9e37_79b9 * (i + 1);
            wb_write(make_adr(SLV_BOOT, 16'(i * 4)), boot_model[i]);
        end
        for (int n = 0; n < 64; n++) begin
            idx = $urandom_range(BOOT_WORDS - 1);
            dat = $urandom;
            sel = 4'($urandom);
            wb_write(make_adr(SLV_BOOT, 16'(idx * 4)), dat, sel);
            boot_model[idx] = merge_bytes(boot_model[idx], dat, sel);
        end
        for (int n = 0; n < 64; n++) begin
            idx = $urandom_range(BOOT_WORDS - 1);
            wb_read(make_adr(SLV_BOOT, 16'(idx * 4)), rdat);
            check(rdat, boot_model[idx], "boot word");
        end
    endtask

    task automatic test_led();
        logic [31:0] rdat;
        for (int n = 0; n < 8; n++) begin
            led_m = 4'($urandom);
            wb_write(make_adr(SLV_TEST, TEST_LED), {28'h0, led_m});
            check(led, led_m, "o_led pins");
            wb_read(make_adr(SLV_TEST, TEST_LED), rdat);
            check(rdat, {28'h0, led_m}, "LED readback");
        end
    endtask

    task automatic test_unmapped();
        logic [31:0] rdat;
        logic        ack;
        logic        err;
        int          idx;
        for (int n = 0; n < 16; n++) begin
            // Even steps aim at offset zero, home of the LED register
            idx = (n % 2 == 0) ? 0 : $urandom_range(BOOT_WORDS - 1);
            bus_access(make_adr(4'($urandom_range(15, 4)), 16'(idx * 4)), 1'($urandom),
                       4'hf, $urandom, rdat, ack, err);
            check({ack, err}, 2'b01, "unmapped response");
            check(rdat, 32'h0, "unmapped read data");
            // Boot word behind the same offset
            wb_read(make_adr(SLV_BOOT, 16'(idx * 4)), rdat);
            check(rdat, boot_model[idx], "boot word after unmapped");
        end
        // State untouched
        wb_read(make_adr(SLV_TEST, TEST_LED), rdat);
        check(rdat, {28'h0, led_m}, "LED after unmapped");
        verify_ic("after unmapped");
    endtask

    task automatic test_interrupts();
        logic [NSRC-1:0] bits;
        for (int n = 0; n < 16; n++) begin
            bits = NSRC'($urandom);
            case ($urandom_range(4))
                0: begin
                    test_m = 2'($urandom);
                    wb_write(make_adr(SLV_TEST, TEST_IRQ), {30'h0, test_m});
                end
                1: begin
                    irq_en_m = irq_en_m | bits;
                    wb_write(make_adr(SLV_IC, IC_IRQ_EN_SET), 32'(bits));
                end
                2: begin
                    irq_en_m = irq_en_m & ~bits;
                    wb_write(make_adr(SLV_IC, IC_IRQ_EN_CLR), 32'(bits));
                end
                3: begin
                    firq_en_m = firq_en_m | bits;
                    wb_write(make_adr(SLV_IC, IC_FIRQ_EN_SET), 32'(bits));
                end
                default: begin
                    firq_en_m = firq_en_m & ~bits;
                    wb_write(make_adr(SLV_IC, IC_FIRQ_EN_CLR), 32'(bits));
                end
            endcase
            verify_ic("random irq step");
        end
        // Directed pass raising both, then dropping them by enable and by source
        wb_write(make_adr(SLV_IC, IC_IRQ_EN_CLR), 32'hffff_ffff);
        wb_write(make_adr(SLV_IC, IC_FIRQ_EN_CLR), 32'hffff_ffff);
        irq_en_m  = '0;
        firq_en_m = '0;
        test_m    = 2'b11;
        wb_write(make_adr(SLV_TEST, TEST_IRQ), 32'h3);
        wb_write(make_adr(SLV_IC, IC_IRQ_EN_SET), 32'h1);
        wb_write(make_adr(SLV_IC, IC_FIRQ_EN_SET), 32'h2);
        irq_en_m  = 'h1;
        firq_en_m = 'h2;
        verify_ic("both raised");
        wb_write(make_adr(SLV_IC, IC_IRQ_EN_CLR), 32'h1);
        irq_en_m = '0;
        verify_ic("irq enable cleared");
        test_m = 2'b00;
        wb_write(make_adr(SLV_TEST, TEST_IRQ), 32'h0);
        verify_ic("firq source cleared");
        wb_write(make_adr(SLV_IC, IC_FIRQ_EN_CLR), 32'hffff_ffff);
        firq_en_m = '0;
    endtask

    task automatic test_timers();
        logic [31:0] rdat;
        logic [15:0] base;
        int          load;
        int          polls;
        logic        found;
        for (int t = 0; t < TIMERS; t++) begin
            base = 16'(t) * TIMER_STRIDE;
            load = $urandom_range(24, 4);
            wb_write(make_adr(SLV_TIMER, base + TMR_LOAD), 32'(load));
            wb_read(make_adr(SLV_TIMER, base + TMR_VALUE), rdat);
            check(rdat, 32'(load), "timer value after load");
            // Disabled timer stays quiet
            repeat (load + 4) @(negedge clk);
            verify_ic("timer disabled");
            irq_en_m[SRC_TIMER_BASE + t] = 1'b1;
            wb_write(make_adr(SLV_IC, IC_IRQ_EN_SET), 32'(1) << (SRC_TIMER_BASE + t));
            wb_write(make_adr(SLV_TIMER, base + TMR_CTRL), 32'h1);
            found = 1'b0;
            polls = 0;
            while (!found && polls < load + 8) begin
                wb_read(make_adr(SLV_IC, IC_RAW), rdat);
                found = rdat[SRC_TIMER_BASE + t];
                polls++;
            end
            if (!found) begin
                timeouts++;
                $display("Timer %0d flag never appeared in the raw status", t);
            end
            flag_m[t] = 1'b1;
            wb_write(make_adr(SLV_TIMER, base + TMR_CTRL), 32'h0);
            verify_ic("timer flag set");
            wb_write(make_adr(SLV_TIMER, base + TMR_CLEAR), 32'h1);
            flag_m[t] = 1'b0;
            verify_ic("timer flag cleared");
            wb_write(make_adr(SLV_IC, IC_IRQ_EN_CLR), 32'(1) << (SRC_TIMER_BASE + t));
            irq_en_m[SRC_TIMER_BASE + t] = 1'b0;
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        void'($urandom(32'h4fad45e1));
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        reset     = 1'b1;
        wb_adr    = '0;
        wb_sel    = '0;
        wb_we     = 1'b0;
        wb_dat_w  = '0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        led_m     = '0;
        test_m    = '0;
        irq_en_m  = '0;
        firq_en_m = '0;
        flag_m    = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        test_boot_mem();
        test_led();
        test_unmapped();
        test_interrupts();
        test_timers();
        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* verification/amber_sys_asserts.sv */
// Wishbone protocol assertions, bound into the fabric top level for simulation
`timescale 1ns/1ns

module amber_sys_asserts (
    input logic i_clk,
    input logic i_reset,
    input logic i_wb_cyc,
    input logic i_wb_stb,
    input logic i_wb_ack,
    input logic i_wb_err
);

    // Never both responses in one cycle
    a_ack_err_excl: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_wb_ack && i_wb_err))
        else $error("ack and err high in the same cycle");

    // A response needs a request one cycle earlier
    a_resp_after_req: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_wb_ack || i_wb_err) |-> $past(i_wb_cyc && i_wb_stb))
        else $error("response without a preceding cyc and stb cycle");

    // Single-cycle ack pulse
    a_ack_single: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wb_ack |=> !i_wb_ack)
        else $error("ack held high for two cycles");

endmodule

bind amber_sys amber_sys_asserts u_asserts (
    .i_clk    ( i_clk    ),
    .i_reset  ( i_reset  ),
    .i_wb_cyc ( i_wb_cyc ),
    .i_wb_stb ( i_wb_stb ),
    .i_wb_ack ( o_wb_ack ),
    .i_wb_err ( o_wb_err )
);

/* verilog/amber_sys.sv */
// Fabric top level; one Wishbone slave port feeding decoder, boot RAM, test, timer and IC
`timescale 1ns/1ns

module amber_sys #(
    parameter int TIMERS     = 3,
    parameter int BOOT_WORDS = 256
) (
    input  logic                                  i_clk,
    input  logic                                  i_reset,

    // Wishbone slave port, driven by the external master
    input  amber_sys_pkg::wb_adr_t                i_wb_adr,
    input  logic [amber_sys_pkg::WB_SWIDTH-1:0]   i_wb_sel,
    input  logic                                  i_wb_we,
    input  logic [amber_sys_pkg::WB_DWIDTH-1:0]   i_wb_dat,
    input  logic                                  i_wb_cyc,
    input  logic                                  i_wb_stb,
    output logic [amber_sys_pkg::WB_DWIDTH-1:0]   o_wb_dat,
    output logic                                  o_wb_ack,
    output logic                                  o_wb_err,

    output logic [3:0]                            o_led,
    output logic                                  o_irq,
    output logic                                  o_firq
);

    import amber_sys_pkg::*;

    // Per-slave strobes and responses
    logic                 boot_stb;
    logic                 test_stb;
    logic                 timer_stb;
    logic                 ic_stb;
    logic [WB_DWIDTH-1:0] boot_dat;
    logic [WB_DWIDTH-1:0] test_dat;
    logic [WB_DWIDTH-1:0] timer_dat;
    logic [WB_DWIDTH-1:0] ic_dat;
    logic                 boot_ack;
    logic                 test_ack;
    logic                 timer_ack;
    logic                 ic_ack;

    // Interrupt sources
    logic                 test_irq;
    logic                 test_firq;
    logic [TIMERS-1:0]    timer_int;
    logic [TIMERS+1:0]    sources;

    assign sources[SRC_TEST_IRQ]              = test_irq;
    assign sources[SRC_TEST_FIRQ]             = test_firq;
    assign sources[SRC_TIMER_BASE +: TIMERS]  = timer_int;

    // ------------------------------
    // Address decode
    // ------------------------------
    wb_decoder u_wb_decoder (
        .i_clk        ( i_clk     ),
        .i_reset      ( i_reset   ),
        .i_wb_adr     ( i_wb_adr  ),
        .i_wb_cyc     ( i_wb_cyc  ),
        .i_wb_stb     ( i_wb_stb  ),
        .i_boot_dat   ( boot_dat  ),
        .i_boot_ack   ( boot_ack  ),
        .i_test_dat   ( test_dat  ),
        .i_test_ack   ( test_ack  ),
        .i_timer_dat  ( timer_dat ),
        .i_timer_ack  ( timer_ack ),
        .i_ic_dat     ( ic_dat    ),
        .i_ic_ack     ( ic_ack    ),
        .o_boot_stb   ( boot_stb  ),
        .o_test_stb   ( test_stb  ),
        .o_timer_stb  ( timer_stb ),
        .o_ic_stb     ( ic_stb    ),
        .o_wb_dat     ( o_wb_dat  ),
        .o_wb_ack     ( o_wb_ack  ),
        .o_wb_err     ( o_wb_err  )
    );

    // ------------------------------
    // Slaves
    // ------------------------------
    boot_mem #(
        .BOOT_WORDS ( BOOT_WORDS )
    ) u_boot_mem (
        .i_clk    ( i_clk    ),
        .i_reset  ( i_reset  ),
        .i_stb    ( boot_stb ),
        .i_wb_we  ( i_wb_we  ),
        .i_wb_sel ( i_wb_sel ),
        .i_wb_adr ( i_wb_adr ),
        .i_wb_dat ( i_wb_dat ),
        .o_wb_dat ( boot_dat ),
        .o_wb_ack ( boot_ack )
    );

    test_module u_test_module (
        .i_clk       ( i_clk     ),
        .i_reset     ( i_reset   ),
        .i_stb       ( test_stb  ),
        .i_wb_we     ( i_wb_we   ),
        .i_wb_adr    ( i_wb_adr  ),
        .i_wb_dat    ( i_wb_dat  ),
        .o_wb_dat    ( test_dat  ),
        .o_wb_ack    ( test_ack  ),
        .o_led       ( o_led     ),
        .o_test_irq  ( test_irq  ),
        .o_test_firq ( test_firq )
    );

    timer_module #(
        .TIMERS ( TIMERS )
    ) u_timer_module (
        .i_clk       ( i_clk     ),
        .i_reset     ( i_reset   ),
        .i_stb       ( timer_stb ),
        .i_wb_we     ( i_wb_we   ),
        .i_wb_adr    ( i_wb_adr  ),
        .i_wb_dat    ( i_wb_dat  ),
        .o_wb_dat    ( timer_dat ),
        .o_wb_ack    ( timer_ack ),
        .o_timer_int ( timer_int )
    );

    interrupt_controller #(
        .TIMERS ( TIMERS )
    ) u_interrupt_controller (
        .i_clk     ( i_clk    ),
        .i_reset   ( i_reset  ),
        .i_stb     ( ic_stb   ),
        .i_wb_we   ( i_wb_we  ),
        .i_wb_adr  ( i_wb_adr ),
        .i_wb_dat  ( i_wb_dat ),
        .i_sources ( sources  ),
        .o_wb_dat  ( ic_dat   ),
        .o_wb_ack  ( ic_ack   ),
        .o_irq     ( o_irq    ),
        .o_firq    ( o_firq   )
    );

endmodule

/* verilog/interrupt_controller.sv */
// Interrupt controller slave; raw sources masked by irq and firq enables
`timescale 1ns/1ns

module interrupt_controller #(
    parameter int TIMERS = 3
) (
    input  logic                                  i_clk,
    input  logic                                  i_reset,
    input  logic                                  i_stb,
    input  logic                                  i_wb_we,
    input  amber_sys_pkg::wb_adr_t                i_wb_adr,
    input  logic [amber_sys_pkg::WB_DWIDTH-1:0]   i_wb_dat,
    input  logic [TIMERS+1:0]                     i_sources,
    output logic [amber_sys_pkg::WB_DWIDTH-1:0]   o_wb_dat,
    output logic                                  o_wb_ack,
    output logic                                  o_irq,
    output logic                                  o_firq
);

    import amber_sys_pkg::*;

    localparam int NSRC = TIMERS + 2;

    logic [NSRC-1:0]      irq_en;
    logic [NSRC-1:0]      firq_en;
    logic [NSRC-1:0]      irq_status;
    logic [NSRC-1:0]      firq_status;
    logic [NSRC-1:0]      wr_bits;
    logic                 access;
    logic [WB_DWIDTH-1:0] rd_data;

    assign access  = i_stb && !o_wb_ack;
    assign wr_bits = i_wb_dat[NSRC-1:0];

    // Status is live raw AND enable
    assign irq_status  = i_sources & irq_en;
    assign firq_status = i_sources & firq_en;

    // Readback; set registers return the mask, clear registers read zero
    always_comb begin
        rd_data = '0;
        case (i_wb_adr.f.offset)
            IC_RAW:         rd_data[NSRC-1:0] = i_sources;
            IC_IRQ_STATUS:  rd_data[NSRC-1:0] = irq_status;
            IC_IRQ_EN_SET:  rd_data[NSRC-1:0] = irq_en;
            IC_FIRQ_STATUS: rd_data[NSRC-1:0] = firq_status;
            IC_FIRQ_EN_SET: rd_data[NSRC-1:0] = firq_en;
            default:        rd_data = '0;
        endcase
    end

    // ------------------------------
    // Enable masks and outputs
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_ack <= 1'b0;
            irq_en   <= '0;
            firq_en  <= '0;
            o_irq    <= 1'b0;
            o_firq   <= 1'b0;
        end else begin
            o_wb_ack <= access;
            if (access && i_wb_we) begin
                case (i_wb_adr.f.offset)
                    IC_IRQ_EN_SET:  irq_en  <= irq_en | wr_bits;
                    IC_IRQ_EN_CLR:  irq_en  <= irq_en & ~wr_bits;
                    IC_FIRQ_EN_SET: firq_en <= firq_en | wr_bits;
                    IC_FIRQ_EN_CLR: firq_en <= firq_en & ~wr_bits;
                    default:        ;
                endcase
            end
            // One cycle behind sources and enables
            o_irq  <= |irq_status;
            o_firq <= |firq_status;
        end
    end

    always_ff @(posedge i_clk) begin
        if (access) begin
            o_wb_dat <= rd_data;
        end
    end

endmodule

/* verilog/timer_module.sv */
// Bank of periodic down-counting timers, each raising a sticky flag on reload
`timescale 1ns/1ns

module timer_module #(
    parameter int TIMERS = 3
) (
    input  logic                                  i_clk,
    input  logic                                  i_reset,
    input  logic                                  i_stb,
    input  logic                                  i_wb_we,
    input  amber_sys_pkg::wb_adr_t                i_wb_adr,
    input  logic [amber_sys_pkg::WB_DWIDTH-1:0]   i_wb_dat,
    output logic [amber_sys_pkg::WB_DWIDTH-1:0]   o_wb_dat,
    output logic                                  o_wb_ack,
    output logic [TIMERS-1:0]                     o_timer_int
);

    import amber_sys_pkg::*;

    logic [WB_DWIDTH-1:0] load_r  [TIMERS];
    logic [WB_DWIDTH-1:0] count_r [TIMERS];
    logic [TIMERS-1:0]    en_r;
    logic [TIMERS-1:0]    flag_r;
    logic [15:0]          tmr_idx;
    logic [15:0]          tmr_reg;
    logic                 access;
    logic                 wr_en;
    logic [WB_DWIDTH-1:0] rd_data;

    // Timer window and register within it
    assign tmr_idx = i_wb_adr.f.offset / TIMER_STRIDE;
    assign tmr_reg = i_wb_adr.f.offset % TIMER_STRIDE;

    assign access = i_stb && !o_wb_ack;
    assign wr_en  = access && i_wb_we;

    assign o_timer_int = flag_r;

    // ------------------------------
    // Counters and register writes
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            en_r   <= '0;
            flag_r <= '0;
            for (int t = 0; t < TIMERS; t++) begin
                load_r[t]  <= '0;
                count_r[t] <= '0;
            end
        end else begin
            for (int t = 0; t < TIMERS; t++) begin
                // Count down, reload and flag at zero
                if (en_r[t]) begin
                    if (count_r[t] == '0) begin
                        count_r[t] <= load_r[t];
                        flag_r[t]  <= 1'b1;
                    end else begin
                        count_r[t] <= count_r[t] - 1'b1;
                    end
                end
                // Bus write wins over the count
                if (wr_en && (tmr_idx == 16'(t))) begin
                    case (tmr_reg)
                        TMR_LOAD: begin
                            load_r[t]  <= i_wb_dat;
                            count_r[t] <= i_wb_dat;
                        end
                        TMR_CTRL:  en_r[t]   <= i_wb_dat[0];
                        TMR_CLEAR: flag_r[t] <= 1'b0;
                        default:   ;
                    endcase
                end
            end
        end
    end

    // Readback; out-of-range timers and CLEAR read zero
    always_comb begin
        rd_data = '0;
        for (int t = 0; t < TIMERS; t++) begin
            if (tmr_idx == 16'(t)) begin
                case (tmr_reg)
                    TMR_LOAD:  rd_data = load_r[t];
                    TMR_VALUE: rd_data = count_r[t];
                    TMR_CTRL:  rd_data[0] = en_r[t];
                    default:   rd_data = '0;
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (access) begin
            o_wb_dat <= rd_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= access;
        end
    end

endmodule

/* verilog/test_module.sv */
// Test slave holding the LED register and software-driven irq/firq levels
`timescale 1ns/1ns

module test_module (
    input  logic                                  i_clk,
    input  logic                                  i_reset,
    input  logic                                  i_stb,
    input  logic                                  i_wb_we,
    input  amber_sys_pkg::wb_adr_t                i_wb_adr,
    input  logic [amber_sys_pkg::WB_DWIDTH-1:0]   i_wb_dat,
    output logic [amber_sys_pkg::WB_DWIDTH-1:0]   o_wb_dat,
    output logic                                  o_wb_ack,
    output logic [3:0]                            o_led,
    output logic                                  o_test_irq,
    output logic                                  o_test_firq
);

    import amber_sys_pkg::*;

    logic                 access;
    logic [WB_DWIDTH-1:0] rd_data;

    assign access = i_stb && !o_wb_ack;

    // Readback mux
    always_comb begin
        rd_data = '0;
        case (i_wb_adr.f.offset)
            TEST_LED: rd_data[3:0] = o_led;
            TEST_IRQ: rd_data[1:0] = {o_test_firq, o_test_irq};
            default:  rd_data = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_ack    <= 1'b0;
            o_led       <= 4'd0;
            o_test_irq  <= 1'b0;
            o_test_firq <= 1'b0;
        end else begin
            o_wb_ack <= access;
            if (access && i_wb_we) begin
                if (i_wb_adr.f.offset == TEST_LED) begin
                    o_led <= i_wb_dat[3:0];
                end
                // Software sets and clears both levels at once
                if (i_wb_adr.f.offset == TEST_IRQ) begin
                    o_test_irq  <= i_wb_dat[0];
                    o_test_firq <= i_wb_dat[1];
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (access) begin
            o_wb_dat <= rd_data;
        end
    end

endmodule

/* verilog/boot_mem.sv */
// On-chip boot RAM slave, word addressed, with per-byte write enables
`timescale 1ns/1ns

module boot_mem #(
    parameter int BOOT_WORDS = 256
) (
    input  logic                                  i_clk,
    input  logic                                  i_reset,
    input  logic                                  i_stb,
    input  logic                                  i_wb_we,
    input  logic [amber_sys_pkg::WB_SWIDTH-1:0]   i_wb_sel,
    input  amber_sys_pkg::wb_adr_t                i_wb_adr,
    input  logic [amber_sys_pkg::WB_DWIDTH-1:0]   i_wb_dat,
    output logic [amber_sys_pkg::WB_DWIDTH-1:0]   o_wb_dat,
    output logic                                  o_wb_ack
);

    import amber_sys_pkg::*;

    localparam int AW = $clog2(BOOT_WORDS);

    logic [WB_DWIDTH-1:0] mem [BOOT_WORDS];
    logic [AW-1:0]        word_idx;
    logic                 access;

    // Byte offset to word index
    assign word_idx = i_wb_adr.f.offset[AW+1:2];

    // First cycle of the strobe only
    assign access = i_stb && !o_wb_ack;

    // Selected bytes written, whole word read
    always_ff @(posedge i_clk) begin
        if (access && i_wb_we) begin
            for (int b = 0; b < WB_SWIDTH; b++) begin
                if (i_wb_sel[b]) begin
                    mem[word_idx][b*8 +: 8] <= i_wb_dat[b*8 +: 8];
                end
            end
        end
        if (access) begin
            o_wb_dat <= mem[word_idx];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= access;
        end
    end

endmodule

/* verilog/wb_decoder.sv */
// Slave-field decoder; fans strobes out, merges responses and errors unmapped slaves
`timescale 1ns/1ns

module wb_decoder (
    input  logic                                  i_clk,
    input  logic                                  i_reset,
    input  amber_sys_pkg::wb_adr_t                i_wb_adr,
    input  logic                                  i_wb_cyc,
    input  logic                                  i_wb_stb,

    input  logic [amber_sys_pkg::WB_DWIDTH-1:0]   i_boot_dat,
    input  logic                                  i_boot_ack,
    input  logic [amber_sys_pkg::WB_DWIDTH-1:0]   i_test_dat,
    input  logic                                  i_test_ack,
    input  logic [amber_sys_pkg::WB_DWIDTH-1:0]   i_timer_dat,
    input  logic                                  i_timer_ack,
    input  logic [amber_sys_pkg::WB_DWIDTH-1:0]   i_ic_dat,
    input  logic                                  i_ic_ack,

    output logic                                  o_boot_stb,
    output logic                                  o_test_stb,
    output logic                                  o_timer_stb,
    output logic                                  o_ic_stb,
    output logic [amber_sys_pkg::WB_DWIDTH-1:0]   o_wb_dat,
    output logic                                  o_wb_ack,
    output logic                                  o_wb_err
);

    import amber_sys_pkg::*;

    logic req;
    logic unmapped;

    // Bus request this cycle
    assign req = i_wb_cyc && i_wb_stb;

    // One-hot strobes from the slave field
    assign o_boot_stb  = req && (i_wb_adr.f.slave == SLV_BOOT);
    assign o_test_stb  = req && (i_wb_adr.f.slave == SLV_TEST);
    assign o_timer_stb = req && (i_wb_adr.f.slave == SLV_TIMER);
    assign o_ic_stb    = req && (i_wb_adr.f.slave == SLV_IC);

    // Fields 4 to 15 hit nothing
    assign unmapped = i_wb_adr.f.slave > SLV_IC;

    // Only the addressed slave can ack, so the OR is the mux
    assign o_wb_ack = i_boot_ack || i_test_ack || i_timer_ack || i_ic_ack;

    // Read data of the addressed slave, zero when unmapped
    always_comb begin
        case (i_wb_adr.f.slave)
            SLV_BOOT:  o_wb_dat = i_boot_dat;
            SLV_TEST:  o_wb_dat = i_test_dat;
            SLV_TIMER: o_wb_dat = i_timer_dat;
            SLV_IC:    o_wb_dat = i_ic_dat;
            default:   o_wb_dat = '0;
        endcase
    end

    // Error pulse one cycle after an unmapped strobe
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_err <= 1'b0;
        end else begin
            o_wb_err <= req && unmapped && !o_wb_err;
        end
    end

endmodule

/* verilog/amber_sys_pkg.sv */
// Shared bus widths, address layout and register map, imported by every fabric module
package amber_sys_pkg;

    // ------------------------------
    // Wishbone widths
    // ------------------------------
    localparam int WB_DWIDTH = 32;
    localparam int WB_SWIDTH = 4;

    // One address word, seen whole or split into slave field and offset
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [3:0]  slave;
            logic [11:0] unused;
            logic [15:0] offset;
        } f;
    } wb_adr_t;

    // ------------------------------
    // Slave map
    // ------------------------------
    localparam logic [3:0] SLV_BOOT  = 4'd0;
    localparam logic [3:0] SLV_TEST  = 4'd1;
    localparam logic [3:0] SLV_TIMER = 4'd2;
    localparam logic [3:0] SLV_IC    = 4'd3;

    // Test module
    localparam logic [15:0] TEST_LED = 16'h0000;
    // Bit 0 irq, bit 1 firq
    localparam logic [15:0] TEST_IRQ = 16'h0004;

    // Timers, one window per timer
    localparam logic [15:0] TIMER_STRIDE = 16'h0100;
    localparam logic [15:0] TMR_LOAD     = 16'h0000;
    localparam logic [15:0] TMR_VALUE    = 16'h0004;
    localparam logic [15:0] TMR_CTRL     = 16'h0008;
    localparam logic [15:0] TMR_CLEAR    = 16'h000c;

    // Interrupt controller
    localparam logic [15:0] IC_RAW         = 16'h0000;
    localparam logic [15:0] IC_IRQ_STATUS  = 16'h0004;
    localparam logic [15:0] IC_IRQ_EN_SET  = 16'h0008;
    localparam logic [15:0] IC_IRQ_EN_CLR  = 16'h000c;
    localparam logic [15:0] IC_FIRQ_STATUS = 16'h0010;
    localparam logic [15:0] IC_FIRQ_EN_SET = 16'h0014;
    localparam logic [15:0] IC_FIRQ_EN_CLR = 16'h0018;

    // Interrupt source positions; timer n sits at SRC_TIMER_BASE + n
    localparam int SRC_TEST_IRQ   = 0;
    localparam int SRC_TEST_FIRQ  = 1;
    localparam int SRC_TIMER_BASE = 2;

endpackage
